// ==== rtl/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

  localparam int dataWidth = 8;
  localparam int addrWidth = 16;

  // Register codes follow the opcode field order
  typedef logic [2:0] regCode;

  localparam regCode regB     = 3'd0;
  localparam regCode regC     = 3'd1;
  localparam regCode regD     = 3'd2;
  localparam regCode regE     = 3'd3;
  localparam regCode regH     = 3'd4;
  localparam regCode regL     = 3'd5;
  localparam regCode regHlMem = 3'd6;  // Memory at HL, not a register
  localparam regCode regA     = 3'd7;

  typedef enum logic [3:0] {
    fetch,
    readImm,
    readHl,
    writeHl,
    aluOp,
    incReg,
    decReg,
    loadPcLow,
    loadPcHigh,
    jump,
    setIe,
    clearIe,
    interruptJump,
    endFlow
  } uopCmd;

  typedef struct packed {
    uopCmd  cmd;
    logic   incPc;  // Advance PC when the micro-op completes
    logic   last;
    regCode dst;
  } uopWord;

  typedef logic [5:0] flowIndex;

  localparam flowIndex flowFetch     = 6'd0;
  localparam flowIndex flowInterrupt = 6'd1;
  localparam flowIndex flowLast      = 6'd19;  // Highest entry of the micro-op table

  localparam logic [addrWidth-1:0] vectorVblank = 16'h0040;
  localparam logic [addrWidth-1:0] vectorLcd    = 16'h0048;
  localparam logic [addrWidth-1:0] vectorTimer  = 16'h0050;
  localparam logic [addrWidth-1:0] vectorJoypad = 16'h0060;

  localparam logic [dataWidth-1:0] resetValueA = 8'h11;

endpackage

`default_nettype wire

// ==== rtl/microcodeRom.sv ====
`default_nettype none

module microcodeRom
(
  input  wire [cpuPkg::dataWidth-1:0] opcode,
  input  wire cpuPkg::flowIndex       flowAddr,
  output cpuPkg::flowIndex            opcodeFlow,
  output cpuPkg::uopWord              uop
);

  localparam cpuPkg::flowIndex flowNop   = 6'd2;
  localparam cpuPkg::flowIndex flowLdImm = 6'd3;   // Seven entries, B to A
  localparam cpuPkg::flowIndex flowAlu   = 6'd10;  // LD r,r' and the logic ops
  localparam cpuPkg::flowIndex flowInc   = 6'd11;
  localparam cpuPkg::flowIndex flowDec   = 6'd12;
  localparam cpuPkg::flowIndex flowLdAHl = 6'd13;
  localparam cpuPkg::flowIndex flowLdHlA = 6'd14;
  localparam cpuPkg::flowIndex flowJp    = 6'd15;
  localparam cpuPkg::flowIndex flowDi    = 6'd18;
  localparam cpuPkg::flowIndex flowEi    = 6'd19;

  logic [1:0] group;
  logic [2:0] yField;
  logic [2:0] zField;

  assign group  = opcode[7:6];
  assign yField = opcode[5:3];
  assign zField = opcode[2:0];

  function automatic cpuPkg::uopWord makeUop(cpuPkg::uopCmd cmd, logic incPc, logic last,
                                              cpuPkg::regCode dst);
    return {cmd, incPc, last, dst};
  endfunction

  // ------------------------------------------------------------------
  // Opcode to flow
  always_comb
  begin
    opcodeFlow = flowNop;
    if (opcode == 8'hC3)
      opcodeFlow = flowJp;
    else if (opcode == 8'hF3)
      opcodeFlow = flowDi;
    else if (opcode == 8'hFB)
      opcodeFlow = flowEi;
    else if (opcode == 8'h7E)
      opcodeFlow = flowLdAHl;
    else if (opcode == 8'h77)
      opcodeFlow = flowLdHlA;
    else if (group == 2'b01 && yField != cpuPkg::regHlMem && zField != cpuPkg::regHlMem)
      opcodeFlow = flowAlu;
    else if (group == 2'b10 && yField inside {[3'd4:3'd6]} && zField != cpuPkg::regHlMem)
      opcodeFlow = flowAlu;                    // AND, XOR, OR
    else if (group == 2'b00 && yField != cpuPkg::regHlMem)
    begin
      case (zField)
        3'd4:    opcodeFlow = flowInc;
        3'd5:    opcodeFlow = flowDec;
        3'd6:    opcodeFlow = flowLdImm + ((yField == cpuPkg::regA) ? 6'd6 : {3'd0, yField});
        default: opcodeFlow = flowNop;
      endcase
    end
  end

  // ------------------------------------------------------------------
  // Micro-op table
  always_comb
  begin
    case (flowAddr)
      cpuPkg::flowFetch:     uop = makeUop(cpuPkg::fetch, 1'b1, 1'b0, cpuPkg::regA);
      cpuPkg::flowInterrupt: uop = makeUop(cpuPkg::interruptJump, 1'b0, 1'b1, cpuPkg::regA);
      flowNop:               uop = makeUop(cpuPkg::endFlow, 1'b0, 1'b1, cpuPkg::regA);
      flowLdImm:             uop = makeUop(cpuPkg::readImm, 1'b1, 1'b1, cpuPkg::regB);
      flowLdImm + 6'd1:      uop = makeUop(cpuPkg::readImm, 1'b1, 1'b1, cpuPkg::regC);
      flowLdImm + 6'd2:      uop = makeUop(cpuPkg::readImm, 1'b1, 1'b1, cpuPkg::regD);
      flowLdImm + 6'd3:      uop = makeUop(cpuPkg::readImm, 1'b1, 1'b1, cpuPkg::regE);
      flowLdImm + 6'd4:      uop = makeUop(cpuPkg::readImm, 1'b1, 1'b1, cpuPkg::regH);
      flowLdImm + 6'd5:      uop = makeUop(cpuPkg::readImm, 1'b1, 1'b1, cpuPkg::regL);
      flowLdImm + 6'd6:      uop = makeUop(cpuPkg::readImm, 1'b1, 1'b1, cpuPkg::regA);
      flowAlu:               uop = makeUop(cpuPkg::aluOp, 1'b0, 1'b1, cpuPkg::regA);
      flowInc:               uop = makeUop(cpuPkg::incReg, 1'b0, 1'b1, cpuPkg::regA);
      flowDec:               uop = makeUop(cpuPkg::decReg, 1'b0, 1'b1, cpuPkg::regA);
      flowLdAHl:             uop = makeUop(cpuPkg::readHl, 1'b0, 1'b1, cpuPkg::regA);
      flowLdHlA:             uop = makeUop(cpuPkg::writeHl, 1'b0, 1'b1, cpuPkg::regA);
      flowJp:                uop = makeUop(cpuPkg::loadPcLow, 1'b1, 1'b0, cpuPkg::regA);
      flowJp + 6'd1:         uop = makeUop(cpuPkg::loadPcHigh, 1'b1, 1'b0, cpuPkg::regA);
      flowJp + 6'd2:         uop = makeUop(cpuPkg::jump, 1'b0, 1'b1, cpuPkg::regA);
      flowDi:                uop = makeUop(cpuPkg::clearIe, 1'b0, 1'b1, cpuPkg::regA);
      flowEi:                uop = makeUop(cpuPkg::setIe, 1'b0, 1'b1, cpuPkg::regA);
      default:               uop = makeUop(cpuPkg::endFlow, 1'b0, 1'b1, cpuPkg::regA);
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/flowSequencer.sv ====
`default_nettype none

module flowSequencer
(
  input  wire                          iClock,
  input  wire                          reset,
  input  wire cpuPkg::uopWord          uop,
  input  wire cpuPkg::flowIndex        opcodeFlow,
  input  wire                          stall,
  input  wire                          takeInterrupt,
  input  wire                          pcLoad,
  input  wire [cpuPkg::addrWidth-1:0]  pcTarget,
  output cpuPkg::flowIndex             flowAddr,
  output logic [cpuPkg::addrWidth-1:0] pc,
  output logic                         flowActive
);

  typedef enum logic [1:0] {
    stateAfterReset,
    stateStart,
    stateRun,
    stateEnd
  } flowState;

  flowState state;
  logic     stepDone;

  assign flowActive = (state == stateRun);
  assign stepDone   = flowActive && !stall;  // Micro-op completes this cycle

  // ------------------------------------------------------------------
  // Flow state machine
  always_ff @(posedge iClock)
  begin
    if (reset)
      state <= stateAfterReset;
    else
    begin
      case (state)
        stateAfterReset:
          state <= stateStart;
        stateStart:
          state <= stateRun;
        stateRun:
        begin
          if (stepDone && uop.last)
            state <= stateEnd;
        end
        default:
          state <= stateStart;
      endcase
    end
  end

  // Micro program counter
  always_ff @(posedge iClock)
  begin
    if (reset)
      flowAddr <= cpuPkg::flowFetch;
    else if (state == stateStart)
      flowAddr <= takeInterrupt ? cpuPkg::flowInterrupt : cpuPkg::flowFetch;
    else if (stepDone)
    begin
      if (uop.last)
        flowAddr <= cpuPkg::flowFetch;  // Park on fetch between flows
      else if (uop.cmd == cpuPkg::fetch)
        flowAddr <= opcodeFlow;
      else
        flowAddr <= flowAddr + 6'd1;
    end
  end

  // Program counter
  always_ff @(posedge iClock)
  begin
    if (reset)
      pc <= '0;
    else if (stepDone)
    begin
      if (pcLoad)
        pc <= pcTarget;
      else if (uop.incPc)
        pc <= pc + 16'd1;
    end
  end

  assert property (@(posedge iClock) disable iff (reset) flowAddr <= cpuPkg::flowLast)
    else $error("flowAddr %0d outside the micro-op table", flowAddr);

endmodule

`default_nettype wire

// ==== rtl/registerFile.sv ====
`default_nettype none

module registerFile
(
  input  wire                          iClock,
  input  wire                          reset,
  input  wire                          writeEnable,
  input  wire cpuPkg::regCode          writeReg,
  input  wire [cpuPkg::dataWidth-1:0]  writeData,
  input  wire                          flagsWrite,
  input  wire                          zeroFlag,
  input  wire                          subtractFlag,
  input  wire cpuPkg::regCode          readReg,
  output logic [cpuPkg::dataWidth-1:0] readData,
  output logic [cpuPkg::dataWidth-1:0] regA,
  output logic [cpuPkg::addrWidth-1:0] hl,
  output logic                         flagZ,
  output logic                         flagN
);

  // Indexed by register code, entry 6 stays zero
  logic [cpuPkg::dataWidth-1:0] regs [8];

  always_ff @(posedge iClock)
  begin
    if (reset)
    begin
      for (int i = 0; i < 8; i++)
        regs[i] <= '0;
      regs[cpuPkg::regA] <= cpuPkg::resetValueA;
    end
    else if (writeEnable)
      regs[writeReg] <= writeData;
  end

  always_ff @(posedge iClock)
  begin
    if (reset)
    begin
      flagZ <= 1'b0;
      flagN <= 1'b0;
    end
    else if (flagsWrite)
    begin
      flagZ <= zeroFlag;
      flagN <= subtractFlag;
    end
  end

  assign readData = regs[readReg];
  assign regA     = regs[cpuPkg::regA];
  assign hl       = {regs[cpuPkg::regH], regs[cpuPkg::regL]};

  // Memory operands never reach the write port
  assert property (@(posedge iClock) disable iff (reset)
    writeEnable |-> writeReg != cpuPkg::regHlMem)
    else $error("register write with code 6");

endmodule

`default_nettype wire

// ==== rtl/executeUnit.sv ====
`default_nettype none

module executeUnit
(
  input  wire                          iClock,
  input  wire                          reset,
  input  wire cpuPkg::uopWord          uop,
  input  wire                          flowActive,
  output logic [cpuPkg::dataWidth-1:0] opcode,
  input  wire [cpuPkg::addrWidth-1:0]  pc,
  input  wire [cpuPkg::addrWidth-1:0]  hl,
  input  wire [cpuPkg::dataWidth-1:0]  regA,
  input  wire [cpuPkg::dataWidth-1:0]  readData,
  input  wire [cpuPkg::dataWidth-1:0]  memReadData,
  input  wire                          memReady,
  input  wire [cpuPkg::addrWidth-1:0]  vector,
  output logic                         memValid,
  output logic                         memWrite,
  output logic [cpuPkg::addrWidth-1:0] memAddr,
  output logic [cpuPkg::dataWidth-1:0] memWriteData,
  output logic                         stall,
  output cpuPkg::regCode               readReg,
  output logic                         writeEnable,
  output cpuPkg::regCode               writeReg,
  output logic [cpuPkg::dataWidth-1:0] writeData,
  output logic                         flagsWrite,
  output logic                         zeroFlag,
  output logic                         subtractFlag,
  output logic                         pcLoad,
  output logic [cpuPkg::addrWidth-1:0] pcTarget,
  output logic                         setIe,
  output logic                         clearIe
);

  logic [cpuPkg::dataWidth-1:0] opcodeLatch;
  logic [cpuPkg::dataWidth-1:0] targetLow;
  logic [cpuPkg::dataWidth-1:0] targetHigh;
  logic                         busCmd;
  logic                         busDone;
  logic                         hlCmd;
  logic                         fetchDone;

  // ------------------------------------------------------------------
  // Bus handshake
  always_comb
  begin
    case (uop.cmd)
      cpuPkg::fetch, cpuPkg::readImm, cpuPkg::readHl, cpuPkg::writeHl,
      cpuPkg::loadPcLow, cpuPkg::loadPcHigh:
        busCmd = 1'b1;
      default:
        busCmd = 1'b0;
    endcase
  end

  assign hlCmd        = (uop.cmd == cpuPkg::readHl) || (uop.cmd == cpuPkg::writeHl);
  assign memValid     = flowActive && busCmd;
  assign memWrite     = memValid && (uop.cmd == cpuPkg::writeHl);
  assign memAddr      = hlCmd ? hl : pc;
  assign memWriteData = regA;
  assign stall        = memValid && !memReady;
  assign busDone      = memValid && memReady;
  assign fetchDone    = busDone && (uop.cmd == cpuPkg::fetch);

  always_ff @(posedge iClock)
  begin
    if (fetchDone)
      opcodeLatch <= memReadData;
    if (busDone && uop.cmd == cpuPkg::loadPcLow)
      targetLow <= memReadData;
    if (busDone && uop.cmd == cpuPkg::loadPcHigh)
      targetHigh <= memReadData;
  end

  // Bypass so the opcode flow is chosen on the edge the fetch completes
  assign opcode = fetchDone ? memReadData : opcodeLatch;

  // ------------------------------------------------------------------
  // Register, flag and PC controls
  always_comb
  begin
    readReg      = opcodeLatch[2:0];
    writeEnable  = 1'b0;
    writeReg     = uop.dst;
    writeData    = memReadData;
    flagsWrite   = 1'b0;
    subtractFlag = 1'b0;
    pcLoad       = 1'b0;
    pcTarget     = {targetHigh, targetLow};
    case (uop.cmd)
      cpuPkg::readImm, cpuPkg::readHl:
        writeEnable = busDone;
      cpuPkg::aluOp:
      begin
        writeEnable = flowActive;
        if (opcodeLatch[7:6] == 2'b01)   // LD r,r' keeps the flags
        begin
          writeReg  = opcodeLatch[5:3];
          writeData = readData;
        end
        else
        begin
          writeReg   = cpuPkg::regA;
          flagsWrite = flowActive;
          case (opcodeLatch[4:3])
            2'b00:   writeData = regA & readData;
            2'b01:   writeData = regA ^ readData;
            default: writeData = regA | readData;
          endcase
        end
      end
      cpuPkg::incReg, cpuPkg::decReg:
      begin
        readReg      = opcodeLatch[5:3];
        writeReg     = opcodeLatch[5:3];
        writeEnable  = flowActive;
        flagsWrite   = flowActive;
        subtractFlag = (uop.cmd == cpuPkg::decReg);
        writeData    = subtractFlag ? readData - 8'd1 : readData + 8'd1;
      end
      cpuPkg::jump:
        pcLoad = flowActive;
      cpuPkg::interruptJump:
      begin
        pcLoad   = flowActive;
        pcTarget = vector;
      end
      default:
        pcLoad = 1'b0;
    endcase
  end

  assign zeroFlag = (writeData == '0);
  assign setIe    = flowActive && (uop.cmd == cpuPkg::setIe);
  assign clearIe  = flowActive && (uop.cmd == cpuPkg::clearIe);

  // Held request keeps its address until the memory accepts it
  assert property (@(posedge iClock) disable iff (reset)
    memValid && !memReady |=> memValid && $stable(memAddr))
    else $error("memAddr changed while the request was waiting");

endmodule

`default_nettype wire

// ==== rtl/interruptControl.sv ====
`default_nettype none

module interruptControl
(
  input  wire                          iClock,
  input  wire                          reset,
  input  wire [3:0]                    interruptRequest,
  input  wire                          setIe,
  input  wire                          clearIe,
  input  wire cpuPkg::uopWord          uop,
  output logic                         takeInterrupt,
  output logic [cpuPkg::addrWidth-1:0] vector
);

  logic [3:0] pending;
  logic       enable;
  logic       jumpTaken;

  // Only seen in run flow, the sequencer parks on fetch otherwise
  assign jumpTaken = (uop.cmd == cpuPkg::interruptJump);

  always_ff @(posedge iClock)
  begin
    if (reset)
    begin
      pending <= '0;
      enable  <= 1'b0;
    end
    else
    begin
      pending <= jumpTaken ? 4'b0 : (pending | interruptRequest);
      if (jumpTaken || clearIe)
        enable <= 1'b0;
      else if (setIe)
        enable <= 1'b1;
    end
  end

  assign takeInterrupt = enable && (pending != 4'b0);

  // Lowest pending bit wins
  always_comb
  begin
    if (pending[0])
      vector = cpuPkg::vectorVblank;
    else if (pending[1])
      vector = cpuPkg::vectorLcd;
    else if (pending[2])
      vector = cpuPkg::vectorTimer;
    else
      vector = cpuPkg::vectorJoypad;
  end

endmodule

`default_nettype wire

// ==== rtl/cpuCore.sv ====
`default_nettype none

module cpuCore
(
  input  wire                         iClock,
  input  wire                         reset,
  output wire                         memValid,
  output wire                         memWrite,
  output wire [cpuPkg::addrWidth-1:0] memAddr,
  output wire [cpuPkg::dataWidth-1:0] memWriteData,
  input  wire                         memReady,
  input  wire [cpuPkg::dataWidth-1:0] memReadData,
  input  wire [3:0]                   interruptRequest
);

  // ------------------------------------------------------------------
  // Sequencing and microcode
  wire cpuPkg::uopWord          uop;
  wire cpuPkg::flowIndex        flowAddr;
  wire cpuPkg::flowIndex        opcodeFlow;
  wire [cpuPkg::dataWidth-1:0]  opcode;
  wire [cpuPkg::addrWidth-1:0]  pc;
  wire                          flowActive;
  wire                          stall;
  wire                          pcLoad;
  wire [cpuPkg::addrWidth-1:0]  pcTarget;

  // Register file
  wire cpuPkg::regCode          readReg;
  wire [cpuPkg::dataWidth-1:0]  readData;
  wire [cpuPkg::dataWidth-1:0]  regA;
  wire [cpuPkg::addrWidth-1:0]  hl;
  wire                          writeEnable;
  wire cpuPkg::regCode          writeReg;
  wire [cpuPkg::dataWidth-1:0]  writeData;
  wire                          flagsWrite;
  wire                          zeroFlag;
  wire                          subtractFlag;

  // Interrupts
  wire                          takeInterrupt;
  wire [cpuPkg::addrWidth-1:0]  vector;
  wire                          setIe;
  wire                          clearIe;

  flowSequencer sequencer (.*);

  microcodeRom rom (.*);

  // No branch in this subset reads the flags
  registerFile regFile (.*, .flagZ(), .flagN());

  executeUnit execute (.*);

  interruptControl interrupts (.*);

endmodule

`default_nettype wire

// ==== verification/tbMemory.sv ====
`default_nettype none

module tbMemory
(
  input  wire        iClock,
  input  wire        reset,
  input  wire        memValid,
  input  wire        memWrite,
  input  wire [15:0] memAddr,
  input  wire [7:0]  memWriteData,
  output logic       memReady,
  output logic [7:0] memReadData
);

  logic [7:0]  mem [65536];
  logic [31:0] readyState;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] stepLfsr(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  initial
  begin
    for (int i = 0; i < 65536; i++)
      mem[i] = i[15:8] ^ i[7:0] ^ 8'h5A;
    readyState = 32'd70526;
    memReady   = 1'b0;
  end

  assign memReadData = mem[memAddr];  // Read data follows the held address

  always @(posedge iClock)
  begin
    readyState = stepLfsr(readyState);
    memReady <= readyState[0];
    if (!reset && memValid && memWrite && memReady)
      mem[memAddr] <= memWriteData;
  end

endmodule

`default_nettype wire

// ==== verification/cpuTb.sv ====
`default_nettype none

module cpuTb;

  logic        iClock;
  logic        reset;
  logic [3:0]  interruptRequest;
  wire         memValid;
  wire         memWrite;
  wire  [15:0] memAddr;
  wire  [7:0]  memWriteData;
  wire         memReady;
  wire  [7:0]  memReadData;

  // Expected bus transfers in order
  logic        expWrite [$];
  logic [15:0] expAddr [$];
  logic [7:0]  expData [$];
  // Fetch addresses that raise interrupt requests
  logic [15:0] trigAddr [$];
  logic [3:0]  trigBits [$];

  logic [7:0]  modelRegs [8];
  logic [7:0]  modelMem [65536];
  logic [15:0] asmPc;
  logic [31:0] lfsrState;
  int          mismatchCount;
  int          failureCount;
  int          waitCycles;

  cpuCore UUT (.*);

  tbMemory memory (.*);

  always #2 iClock = ~iClock;

  function automatic logic [31:0] stepLfsr(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  function automatic logic [7:0] randomBits(input int n);
    logic [7:0] value;
    value = 8'd0;
    for (int i = 0; i < n; i++)
    begin
      lfsrState = stepLfsr(lfsrState);
      value = {value[6:0], lfsrState[0]};
    end
    return value;
  endfunction

  // ----------------------------------------------------------------------
  // Program builder and reference model
  task automatic expectTransfer(input logic write, input logic [15:0] addr, input logic [7:0] data);
    expWrite.push_back(write);
    expAddr.push_back(addr);
    expData.push_back(data);
  endtask

  task automatic putByte(input logic [7:0] value);
    memory.mem[asmPc] = value;
    asmPc = asmPc + 16'd1;
  endtask

  task automatic opFetch(input logic [7:0] op);
    expectTransfer(1'b0, asmPc, 8'h00);
    putByte(op);
  endtask

  task automatic loadImmediate(input logic [2:0] dst, input logic [7:0] value);
    opFetch(8'h06 | {2'b00, dst, 3'b000});
    expectTransfer(1'b0, asmPc, 8'h00);
    putByte(value);
    modelRegs[dst] = value;
  endtask

  task automatic moveReg(input logic [2:0] dst, input logic [2:0] src);
    opFetch({2'b01, dst, src});
    modelRegs[dst] = modelRegs[src];
  endtask

  task automatic logicOp(input logic [1:0] kind, input logic [2:0] src);
    opFetch({2'b10, 1'b1, kind, src});
    case (kind)
      2'd0:    modelRegs[7] = modelRegs[7] & modelRegs[src];
      2'd1:    modelRegs[7] = modelRegs[7] ^ modelRegs[src];
      default: modelRegs[7] = modelRegs[7] | modelRegs[src];
    endcase
  endtask

  task automatic stepReg(input logic [2:0] dst, input logic down);
    opFetch({2'b00, dst, 2'b10, down});
    modelRegs[dst] = down ? modelRegs[dst] - 8'd1 : modelRegs[dst] + 8'd1;
  endtask

  task automatic storeA();
    opFetch(8'h77);
    expectTransfer(1'b1, {modelRegs[4], modelRegs[5]}, modelRegs[7]);
    modelMem[{modelRegs[4], modelRegs[5]}] = modelRegs[7];
  endtask

  task automatic loadA();
    opFetch(8'h7E);
    expectTransfer(1'b0, {modelRegs[4], modelRegs[5]}, 8'h00);
    modelRegs[7] = modelMem[{modelRegs[4], modelRegs[5]}];
  endtask

  task automatic jumpTo(input logic [15:0] target);
    opFetch(8'hC3);
    expectTransfer(1'b0, asmPc, 8'h00);
    putByte(target[7:0]);
    expectTransfer(1'b0, asmPc, 8'h00);
    putByte(target[15:8]);
    asmPc = target;
  endtask

  task automatic nopWithRequest(input logic [3:0] bits);
    trigAddr.push_back(asmPc);
    trigBits.push_back(bits);
    opFetch(8'h00);
  endtask

  task automatic buildProgram();
    logic [2:0] destCodes [5];
    logic [2:0] pick;
    logic [2:0] src;
    logic [2:0] dst;
    logic [15:0] selfAddr;
    destCodes = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd7};
    for (int i = 0; i < 8; i++)
      modelRegs[i] = 8'h00;
    modelRegs[7] = 8'h11;  // A after reset
    asmPc = 16'h0000;
    jumpTo(16'h0100);
    storeA();
    loadImmediate(3'd4, 8'h80);
    loadImmediate(3'd5, 8'h00);
    for (int k = 0; k < 20; k++)
    begin
      pick = 3'(randomBits(3) % 8'd5);
      dst  = destCodes[3'(randomBits(3) % 8'd5)];
      src  = 3'(randomBits(3));
      if (src == 3'd6)
        src = 3'd7;
      case (pick)
        3'd0:    loadImmediate(dst, randomBits(8));
        3'd1:    moveReg(dst, src);
        3'd2:    logicOp(2'(randomBits(2) % 8'd3), src);
        3'd3:    stepReg(dst, 1'b0);
        default: stepReg(dst, 1'b1);
      endcase
      stepReg(3'd5, 1'b0);
      storeA();
    end
    logicOp(2'd1, 3'd7);  // XOR A clears A before the read back
    loadA();
    stepReg(3'd5, 1'b0);
    storeA();
    // Interrupt section
    opFetch(8'hFB);
    nopWithRequest(4'b0110);
    asmPc = 16'h0048;
    nopWithRequest(4'b0001);
    opFetch(8'h00);
    opFetch(8'h00);
    opFetch(8'hFB);
    asmPc = 16'h0040;
    opFetch(8'hFB);  // Enable again so DI has something to clear
    opFetch(8'hF3);
    nopWithRequest(4'b1111);
    opFetch(8'h00);
    jumpTo(16'h0200);
    opFetch(8'h00);
    stepReg(3'd5, 1'b0);
    storeA();
    selfAddr = asmPc;
    jumpTo(selfAddr);
    expectTransfer(1'b0, selfAddr, 8'h00);
  endtask

  // ----------------------------------------------------------------------
  // Checks
  assert property (@(posedge iClock) $past(reset) && reset |-> !memValid)
    else
    begin
      failureCount++;
      $display("memValid was high during reset at %0t", $time);
    end

  assert property (@(posedge iClock) disable iff (reset)
    memValid && !memReady |=> memValid && $stable(memAddr) && $stable(memWrite)
      && $stable(memWriteData))
    else
    begin
      failureCount++;
      $display("Request changed before memReady at %0t", $time);
    end

  always @(posedge iClock)
  begin
    interruptRequest <= 4'b0000;
    if (!reset && memValid && memReady && expAddr.size() > 0)
    begin
      assert (memWrite == expWrite[0])
        else
        begin
          mismatchCount++;
          $display("Mismatch at %0t: memWrite got %b expected %b", $time, memWrite, expWrite[0]);
        end
      assert (memAddr == expAddr[0])
        else
        begin
          mismatchCount++;
          $display("Mismatch at %0t: memAddr got %h expected %h", $time, memAddr, expAddr[0]);
        end
      if (expWrite[0])
        assert (memWriteData == expData[0])
          else
          begin
            mismatchCount++;
            $display("Mismatch at %0t: memWriteData got %h expected %h", $time, memWriteData,
                     expData[0]);
          end
      if (trigAddr.size() > 0 && !memWrite && memAddr == trigAddr[0])
      begin
        interruptRequest <= trigBits[0];  // One cycle pulse after the NOP fetch
        void'(trigAddr.pop_front());
        void'(trigBits.pop_front());
      end
      void'(expWrite.pop_front());
      void'(expAddr.pop_front());
      void'(expData.pop_front());
    end
  end

  // ----------------------------------------------------------------------
  initial
  begin
    iClock           = 1'b0;
    reset            = 1'b1;
    interruptRequest = 4'b0000;
    mismatchCount    = 0;
    failureCount     = 0;
    lfsrState        = 32'd70526;
    @(posedge iClock);
    buildProgram();
    repeat (3) @(posedge iClock);
    reset <= 1'b0;
    waitCycles = 0;
    while (expAddr.size() > 0 && waitCycles < 20000)
    begin
      @(posedge iClock);
      waitCycles++;
    end
    if (expAddr.size() > 0)
    begin
      failureCount++;
      $display("Timed out with %0d bus transfers still expected", expAddr.size());
    end
    repeat (2) @(posedge iClock);
    $display("Errors: %0d mismatches, %0d other failures", mismatchCount, failureCount);
    if (mismatchCount == 0 && failureCount == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
rtl/cpuPkg.sv
rtl/microcodeRom.sv
rtl/flowSequencer.sv
rtl/registerFile.sv
rtl/executeUnit.sv
rtl/interruptControl.sv
rtl/cpuCore.sv
verification/tbMemory.sv
verification/cpuTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f files.f --top-module cpuTb -o cpuSim
./obj_dir/cpuSim > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation finished: PASS" sim.log; then
  exit 0
fi
exit 1
